/* list.f */
aluPkg.sv
add16.sv
shift16.sv
alu.sv
aluWbTop.sv
tbClock.sv
aluTb_chk.sv
aluTb.sv

/* Bender.yml */
package:
  name: alu_wb

sources:
  - files:
      - aluPkg.sv
      - add16.sv
      - shift16.sv
      - alu.sv
      - aluWbTop.sv
  - target: test
    files:
      - tbClock.sv
      - aluTb_chk.sv
      - aluTb.sv

/* aluTb.sv */
`timescale 1ns/10ps

module aluTb
   import aluPkg::*;
();

   // Twice the length of about 600 operations of five two-cycle accesses
   localparam int maxCycles = 2 * (600 * 5 * 2 + 200);
   localparam int numRandom = 300;
   localparam logic [opW-1:0] keptOps [15] = '{opAdd, opSub, opOr, opAnd, opRol, opSll,
      opRor, opSra, opBtr, opSeq, opSlt, opSle, opSco, opLbi, opSlbi};
   localparam logic [dataW-1:0] corners [5] = '{16'h0000, 16'h0001, 16'h7FFF, 16'h8000,
      16'hFFFF};

   logic             clk;
   logic             rstN;
   logic             cyc;
   logic             stb;
   logic             we;
   logic [adrW-1:0]  adr;
   logic [dataW-1:0] datIn;
   logic [dataW-1:0] datOut;
   logic             ack;
   int               seed = 32'h1d8a0c12;
   int               cycleCount = 0;

   tbClock clkGen0 (.clk(clk), .rstN(rstN));

   aluWbTop dut0 (
      .clk    (clk),
      .rstN   (rstN),
      .cyc    (cyc),
      .stb    (stb),
      .we     (we),
      .adr    (adr),
      .datIn  (datIn),
      .datOut (datOut),
      .ack    (ack)
   );

   task automatic abortRun(input string why);
      $display("%s", why);
      $display("CHECKS FAILED");
      $fatal(1, "Run stopped");
   endtask

   // One bus access driven 10 ns after the edge and released after ack
   task automatic busAccess(input logic wr, input logic [adrW-1:0] addr,
                            input logic [dataW-1:0] wdata, output logic [dataW-1:0] rdata);
      @(posedge clk);
      #10;
      cyc   = 1'b1;
      stb   = 1'b1;
      we    = wr;
      adr   = addr;
      datIn = wdata;
      do begin
         @(posedge clk);
         #10;
      end while (!ack);
      rdata = datOut;  // Valid while ack is high
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
   endtask

   task automatic busWrite(input logic [adrW-1:0] addr, input logic [dataW-1:0] data);
      logic [dataW-1:0] unused;
      busAccess(1'b1, addr, data, unused);
   endtask

   task automatic checkRead(input logic [adrW-1:0] addr, input string name,
                            input logic [dataW-1:0] expVal);
      logic [dataW-1:0] got;
      busAccess(1'b0, addr, '0, got);
      assert (got === expVal) else begin
         abortRun($sformatf("Mismatch at %0t ns: %s expected %h got %h",
                            $time, name, expVal, got));
      end
   endtask

   function automatic logic [dataW-1:0] expResult(input logic [dataW-1:0] a, b,
                                                  input logic [opW-1:0] op);
      logic [2*dataW-1:0] dbl;
      logic [dataW-1:0]   r;
      int                 n;
      n = b[3:0];
      r = '0;
      case (op)
         opAdd: r = a + b;
         opSub: r = b - a;
         opOr:  r = a | b;
         opAnd: r = a & b;
         opRol: begin
            dbl = {a, a} << n;
            r = dbl[2*dataW-1:dataW];
         end
         opSll: r = a << n;
         opRor: begin
            dbl = {a, a} >> n;
            r = dbl[dataW-1:0];
         end
         opSra: begin
            r = a >> n;
            for (int i = dataW - n; i < dataW; i++) r[i] = a[dataW-1];
         end
         opBtr: for (int i = 0; i < dataW; i++) r = {r[dataW-2:0], a[i]};
         opSeq: r[0] = (a == b);
         // Signed order by flipping the sign bits
         opSlt: r[0] = ((a ^ 16'h8000) < (b ^ 16'h8000));
         opSle: r[0] = ((a ^ 16'h8000) <= (b ^ 16'h8000));
         opSco: r[0] = (int'(a) + int'(b) > 16'hFFFF);
         opLbi: r = b;
         opSlbi: r = (a << 8) | b;
         default: r = '0;
      endcase
      return r;
   endfunction

   // Signed range check or carry for ADD and borrow for SUB
   function automatic logic expOfl(input logic [dataW-1:0] a, b,
                                   input logic [opW-1:0] op, input logic sign);
      int s;
      if (op == opAdd) begin
         s = sign ? int'($signed(a)) + int'($signed(b)) : int'(a) + int'(b);
         return sign ? (s > 32767 || s < -32768) : (s > 65535);
      end else if (op == opSub) begin
         s = int'($signed(b)) - int'($signed(a));
         return sign ? (s > 32767 || s < -32768) : (b < a);
      end
      return 1'b0;
   endfunction

   task automatic checkOp(input logic [dataW-1:0] a, b, input logic [opW-1:0] op,
                          input logic sign);
      logic [dataW-1:0] ctrl;
      logic [dataW-1:0] res;
      logic [dataW-1:0] stat;
      ctrl = '0;
      ctrl[opW-1:0] = op;
      ctrl[ctrlSignBit] = sign;
      res = expResult(a, b, op);
      stat = '0;
      stat[statZeroBit] = (res == '0);
      stat[statOflBit] = expOfl(a, b, op, sign);
      busWrite(regA, a);
      busWrite(regB, b);
      busWrite(regCtrl, ctrl);
      checkRead(regResult, $sformatf("result (op %0d)", op), res);
      checkRead(regStatus, $sformatf("status (op %0d, sign %0d)", op, sign), stat);
   endtask

   function automatic bit isKept(input int code);
      foreach (keptOps[k]) if (keptOps[k] == code) return 1'b1;
      return 1'b0;
   endfunction

   // Watchdog and protocol failure poll
   always @(negedge clk) begin
      cycleCount++;
      if (cycleCount > maxCycles) begin
         abortRun("Timeout, the tests did not finish within the cycle limit");
      end else if (dut0.wbChk0.failCount != 0) begin
         abortRun("A bus protocol assertion failed");
      end
   end

   initial begin
      logic [dataW-1:0] ra;
      logic [dataW-1:0] rb;
      int               rnd;
      int               ri;
      logic             rs;
      cyc   = 1'b0;
      stb   = 1'b0;
      we    = 1'b0;
      adr   = '0;
      datIn = '0;
      wait (rstN === 1'b1);

      // Reset values then readback and ignored writes
      checkRead(regA, "regA", '0);
      checkRead(regStatus, "regStatus", 16'h0001);
      busWrite(regA, 16'h1234);
      busWrite(regB, 16'hABCD);
      busWrite(regCtrl, 16'h01FF);  // Unused op 31 with sign set
      for (int r = 3; r < 8; r++) begin
         busWrite(r[adrW-1:0], 16'hFFFF);
      end
      checkRead(regA, "regA", 16'h1234);
      checkRead(regB, "regB", 16'hABCD);
      checkRead(regCtrl, "regCtrl", 16'h011F);
      checkRead(regResult, "regResult", '0);
      checkRead(regStatus, "regStatus", 16'h0001);
      for (int r = 5; r < 8; r++) begin
         checkRead(r[adrW-1:0], $sformatf("address %0d", r), '0);
      end

      for (int s = 0; s < 2; s++) begin
         foreach (corners[i]) begin
            foreach (corners[j]) begin
               checkOp(corners[i], corners[j], opAdd, s[0]);
               checkOp(corners[i], corners[j], opSub, s[0]);
            end
         end
      end

      // Upper bits of B must not affect the amount
      for (int m = 4; m < 8; m++) begin
         for (int n = 0; n < 16; n++) begin
            checkOp(16'hB3C5, 16'hA5A0 | n[15:0], keptOps[m], n[0]);
            checkOp(16'h4A39, 16'h5A50 | n[15:0], keptOps[m], ~n[0]);
         end
      end

      for (int k = 2; k < 4; k++) begin
         checkOp(16'hF0F0, 16'h3C3C, keptOps[k], 1'b1);
         checkOp(16'h8001, 16'h0000, keptOps[k], 1'b0);
      end
      checkOp(16'h8001, 16'h0000, opBtr, 1'b0);
      checkOp(16'h1234, 16'hFFFF, opBtr, 1'b1);

      for (int k = 9; k < 12; k++) begin
         checkOp(16'h0005, 16'h0005, keptOps[k], 1'b0);
         checkOp(16'hFFFE, 16'h0002, keptOps[k], 1'b0);
         checkOp(16'h0003, 16'hFFFD, keptOps[k], 1'b1);
         checkOp(16'h8000, 16'h7FFF, keptOps[k], 1'b0);
         checkOp(16'h7FFF, 16'h8000, keptOps[k], 1'b1);
      end
      checkOp(16'hFFFF, 16'h0001, opSco, 1'b0);
      checkOp(16'h1234, 16'h0001, opSco, 1'b0);
      checkOp(16'h9876, 16'h00A5, opLbi, 1'b0);
      checkOp(16'h9876, 16'h00A5, opSlbi, 1'b1);

      for (int c = 0; c < 32; c++) begin
         if (!isKept(c)) begin
            checkOp(16'hFFFF, 16'h1111, c[opW-1:0], 1'b1);
         end
      end

      repeat (numRandom) begin
         rnd = $random(seed);
         ra = rnd[dataW-1:0];
         rnd = $random(seed);
         rb = rnd[dataW-1:0];
         ri = $unsigned($random(seed)) % 15;
         rnd = $random(seed);
         rs = rnd[0];
         checkOp(ra, rb, keptOps[ri], rs);
      end

      if (dut0.wbChk0.failCount == 0) begin
         $display("ALL CHECKS PASSED");
         $finish;
      end else begin
         abortRun("A bus protocol assertion failed");
      end
   end

endmodule

/* aluTb_chk.sv */
`timescale 1ns/10ps

module aluWbChk
   import aluPkg::*;
(
   input logic             clk,
   input logic             rstN,
   input logic             cyc,
   input logic             stb,
   input logic [dataW-1:0] datOut,
   input logic             ack
);

   int failCount = 0;  // Polled by the testbench

   // Slave stays quiet through reset
   ackInReset: assert property (@(posedge clk) !rstN |=> !ack)
      else begin
         $error("ack was high while rstN was low");
         failCount++;
      end

   ackOnlyAfterReq: assert property (@(posedge clk) disable iff (!rstN)
      ack |-> $past(cyc && stb && !ack))
      else begin
         $error("ack rose without a request sampled on the cycle before");
         failCount++;
      end

   // Every new request is answered on the next edge
   ackFollowsReq: assert property (@(posedge clk) disable iff (!rstN)
      cyc && stb && !ack |=> ack)
      else begin
         $error("Request was not acknowledged on the following cycle");
         failCount++;
      end

   ackOneCycle: assert property (@(posedge clk) disable iff (!rstN) ack |=> !ack)
      else begin
         $error("ack stayed high for two cycles in a row");
         failCount++;
      end

   datIdleZero: assert property (@(posedge clk) disable iff (!rstN) !ack |-> datOut == '0)
      else begin
         $error("datOut was not zero outside an acknowledged read");
         failCount++;
      end

endmodule

bind aluWbTop aluWbChk wbChk0 (
   .clk    (clk),
   .rstN   (rstN),
   .cyc    (cyc),
   .stb    (stb),
   .datOut (datOut),
   .ack    (ack)
);

/* tbClock.sv */
`timescale 1ns/10ps

module tbClock (
   output logic clk,
   output logic rstN
);

   localparam int halfPeriod = 50;  // 100 ns clock
   localparam int rstCycles  = 16;

   initial begin
      clk = 1'b0;
      forever #halfPeriod clk = ~clk;
   end

   initial begin
      rstN = 1'b0;
      repeat (rstCycles) @(posedge clk);
      #10 rstN = 1'b1;  // Released off the edge
   end

endmodule

/* aluWbTop.sv */
`timescale 1ns/10ps

module aluWbTop
   import aluPkg::*;
(
   input  logic             clk,
   input  logic             rstN,
   input  logic             cyc,
   input  logic             stb,
   input  logic             we,
   input  logic [adrW-1:0]  adr,
   input  logic [dataW-1:0] datIn,
   output logic [dataW-1:0] datOut,
   output logic             ack
);

   logic [dataW-1:0] aQ;
   logic [dataW-1:0] bQ;
   logic [opW-1:0]   opQ;
   logic             signQ;
   logic             access;
   logic [dataW-1:0] ctrlWord;
   logic [dataW-1:0] statWord;
   logic [dataW-1:0] rdMux;
   logic [dataW-1:0] aluResult;
   logic             aluOfl;
   logic             aluZero;

   // New access only while ack is low, so ack lasts one cycle
   assign access = cyc && stb && !ack;

   always_ff @(posedge clk) begin
      if (!rstN) begin
         ack    <= 1'b0;
         datOut <= '0;
      end else begin
         ack    <= access;
         datOut <= (access && !we) ? rdMux : '0;
      end
   end

   // Operand and control registers
   always_ff @(posedge clk) begin
      if (!rstN) begin
         aQ    <= '0;
         bQ    <= '0;
         opQ   <= '0;
         signQ <= 1'b0;
      end else if (access && we) begin
         case (adr)
            regA:    aQ <= datIn;
            regB:    bQ <= datIn;
            regCtrl: begin
               opQ   <= datIn[opW-1:0];
               signQ <= datIn[ctrlSignBit];
            end
            default: ;  // Read-only and unmapped, ignored
         endcase
      end
   end

   always_comb begin
      ctrlWord              = '0;
      ctrlWord[opW-1:0]     = opQ;
      ctrlWord[ctrlSignBit] = signQ;
   end

   always_comb begin
      statWord              = '0;
      statWord[statZeroBit] = aluZero;
      statWord[statOflBit]  = aluOfl;
   end

   always_comb begin
      case (adr)
         regA:      rdMux = aQ;
         regB:      rdMux = bQ;
         regCtrl:   rdMux = ctrlWord;
         regResult: rdMux = aluResult;
         regStatus: rdMux = statWord;
         default:   rdMux = '0;
      endcase
   end

   // Combinational, follows the registers directly
   alu alu0 (
      .a      (aQ),
      .b      (bQ),
      .op     (opQ),
      .sign   (signQ),
      .result (aluResult),
      .ofl    (aluOfl),
      .zero   (aluZero)
   );

endmodule

/* alu.sv */
`timescale 1ns/10ps

module alu
   import aluPkg::*;
(
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  logic [opW-1:0]   op,
   input  logic             sign,
   output logic [dataW-1:0] result,
   output logic             ofl,
   output logic             zero
);

   logic [dataW-1:0] addA;
   logic [dataW-1:0] addB;
   logic             addCin;
   logic [dataW-1:0] addSum;
   logic             addCout;
   logic             addOvf;
   logic [1:0]       shMode;
   logic [dataW-1:0] shOut;
   logic [dataW-1:0] revA;
   logic             isSub;
   logic             isArith;

   assign isSub   = (op == opSub);
   assign isArith = (op == opAdd) || isSub;

   // SUB is B + ~A + 1
   assign addA   = isSub ? b : a;
   assign addB   = isSub ? ~a : b;
   assign addCin = isSub;

   add16 adder0 (
      .a    (addA),
      .b    (addB),
      .cIn  (addCin),
      .sum  (addSum),
      .cOut (addCout),
      .ovf  (addOvf)
   );

   always_comb begin
      case (op)
         opSll:   shMode = shSll;
         opRor:   shMode = shRor;
         opSra:   shMode = shSra;
         default: shMode = shRol;
      endcase
   end

   shift16 shifter0 (
      .data   (a),
      .amount (b[3:0]),      // Amount from low bits of B
      .mode   (shMode),
      .result (shOut)
   );

   always_comb begin
      for (int i = 0; i < dataW; i++) begin
         revA[i] = a[dataW-1-i];
      end
   end

   // Result select
   always_comb begin
      result = '0;  // Unused and non-computational codes
      case (op)
         opAdd, opSub: result = addSum;
         opOr:         result = a | b;
         opAnd:        result = a & b;
         opRol, opSll, opRor, opSra: begin
            result = shOut;
         end
         opBtr:        result = revA;
         opSeq:        result[0] = (a == b);
         opSlt:        result[0] = ($signed(a) < $signed(b));
         opSle:        result[0] = ($signed(a) <= $signed(b));
         opSco:        result[0] = addCout;  // Adder sees A + B here
         opLbi:        result = b;
         opSlbi:       result = {a[dataW/2-1:0], {(dataW/2){1'b0}}} | b;
         default:      result = '0;
      endcase
   end

   // Signed overflow, or carry for ADD and borrow for SUB
   always_comb begin
      if (!isArith) begin
         ofl = 1'b0;
      end else if (sign) begin
         ofl = addOvf;
      end else begin
         ofl = isSub ? ~addCout : addCout;
      end
   end

   assign zero = (result == '0);

endmodule

/* shift16.sv */
`timescale 1ns/10ps

module shift16
   import aluPkg::*;
(
   input  logic [dataW-1:0] data,
   input  logic [3:0]       amount,
   input  logic [1:0]       mode,
   output logic [dataW-1:0] result
);

   logic [dataW-1:0] stg [0:4];  // Stage outputs, stg[0] is the input

   // One fixed-distance step in the selected mode
   function automatic logic [dataW-1:0] stageShift(input logic [dataW-1:0] d,
                                                   input logic [1:0]       m,
                                                   input int               n);
      logic [dataW-1:0] r;
      case (m)
         shRol:   r = (d << n) | (d >> (dataW - n));
         shSll:   r = d << n;
         shRor:   r = (d >> n) | (d << (dataW - n));
         default: r = $signed(d) >>> n;  // Sign fill
      endcase
      return r;
   endfunction

   assign stg[0] = data;

   // Log shifter, stages of 1, 2, 4 and 8 places
   for (genvar i = 0; i < 4; i++) begin : gStage
      assign stg[i+1] = amount[i] ? stageShift(stg[i], mode, 1 << i) : stg[i];
   end

   assign result = stg[4];

endmodule

/* add16.sv */
`timescale 1ns/10ps

module add16
   import aluPkg::*;
(
   input  logic [dataW-1:0] a,
   input  logic [dataW-1:0] b,
   input  logic             cIn,
   output logic [dataW-1:0] sum,
   output logic             cOut,
   output logic             ovf
);

   logic signA;
   logic signB;
   logic signS;

   // Full-width add, top bit is the carry
   assign {cOut, sum} = a + b + cIn;

   assign signA = a[dataW-1];
   assign signB = b[dataW-1];
   assign signS = sum[dataW-1];

   // Same-sign operands giving a sum of the other sign
   assign ovf = (signA == signB) && (signS != signA);

endmodule

/* aluPkg.sv */
package aluPkg;

   // Datapath and bus widths
   localparam int dataW = 16;
   localparam int opW   = 5;
   localparam int adrW  = 3;

   // Computational opcodes, numbered as in the processor's ISA
   localparam logic [opW-1:0] opAdd  = 5'd0;
   localparam logic [opW-1:0] opSub  = 5'd1;   // B minus A
   localparam logic [opW-1:0] opOr   = 5'd2;
   localparam logic [opW-1:0] opAnd  = 5'd3;
   localparam logic [opW-1:0] opRol  = 5'd4;
   localparam logic [opW-1:0] opSll  = 5'd5;
   localparam logic [opW-1:0] opRor  = 5'd6;
   localparam logic [opW-1:0] opSra  = 5'd7;
   localparam logic [opW-1:0] opBtr  = 5'd11;  // Bit reverse
   localparam logic [opW-1:0] opSeq  = 5'd12;
   localparam logic [opW-1:0] opSlt  = 5'd13;
   localparam logic [opW-1:0] opSle  = 5'd14;
   localparam logic [opW-1:0] opSco  = 5'd15;  // Carry out of A plus B
   localparam logic [opW-1:0] opLbi  = 5'd19;
   localparam logic [opW-1:0] opSlbi = 5'd20;

   // Shifter modes
   localparam logic [1:0] shRol = 2'd0;
   localparam logic [1:0] shSll = 2'd1;
   localparam logic [1:0] shRor = 2'd2;
   localparam logic [1:0] shSra = 2'd3;

   // Register map of the bus slave
   localparam logic [adrW-1:0] regA      = 3'd0;
   localparam logic [adrW-1:0] regB      = 3'd1;
   localparam logic [adrW-1:0] regCtrl   = 3'd2;
   localparam logic [adrW-1:0] regResult = 3'd3;  // Read only
   localparam logic [adrW-1:0] regStatus = 3'd4;  // Read only

   // Field positions in control and status words
   localparam int ctrlSignBit = 8;
   localparam int statZeroBit = 0;
   localparam int statOflBit  = 1;

endpackage
